/* Bender.yml */
package:
  name: speed_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - rtl/speed_ctrl_pkg.sv
      - rtl/decision_if.sv
      - rtl/input_classifier.sv
      - rtl/level_fsm.sv
      - rtl/speed_command.sv
      - rtl/speed_ctrl_top.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/speed_ctrl_properties.sv
      - verification/speed_ctrl_tb.sv

/* include/speed_ctrl_cfg.svh */
`ifndef SPEED_CTRL_CFG_SVH
`define SPEED_CTRL_CFG_SVH

////////////////////////////////////////////////////
// Data widths
////////////////////////////////////////////////////

`define SPEED_WIDTH   8
`define ALERT_WIDTH   3

////////////////////////////////////////////////////
// Comfort levels
////////////////////////////////////////////////////

`define LEVEL_COUNT   8
// Reset level, also where alert-equal steers to
`define LEVEL_NEUTRAL 4

////////////////////////////////////////////////////
// Speed steps
////////////////////////////////////////////////////

`define STEP_SMALL    5
`define STEP_MID      10
`define STEP_LARGE    15
// Slow class cut and largest offset
`define STEP_SLOW     20

`endif

/* list.f */
+incdir+include
rtl/speed_ctrl_pkg.sv
rtl/decision_if.sv
rtl/input_classifier.sv
rtl/level_fsm.sv
rtl/speed_command.sv
rtl/speed_ctrl_top.sv
verification/clock_gen.sv
verification/speed_ctrl_properties.sv
verification/speed_ctrl_tb.sv

/* rtl/decision_if.sv */
`timescale 1ns/100ps

interface decision_if;
    import speed_ctrl_pkg::*;

    alert_class_t alert_class;
    relation_t    relation;
    speed_t       speed_set;
    speed_t       speed_now;

    modport source (
        output alert_class,
        output relation,
        output speed_set,
        output speed_now
    );

    modport sink (
        input alert_class,
        input relation,
        input speed_set,
        input speed_now
    );

endinterface

/* rtl/input_classifier.sv */
`timescale 1ns/100ps

module input_classifier (
    input  logic                         clock,
    input  logic                         rst_n,
    input  speed_ctrl_pkg::speed_t       speed_set,
    input  speed_ctrl_pkg::speed_t       speed_now,
    input  speed_ctrl_pkg::alert_code_t  alertness,
    decision_if.source                   dec
);
    import speed_ctrl_pkg::*;

    alert_class_t class_d;
    relation_t    relation_d;

    // Alertness decode, any code with the top bit set is alert
    always_comb begin
        casez (alertness)
            3'b000:  class_d = cls_stop;
            3'b001:  class_d = cls_slow;
            3'b01?:  class_d = cls_drowsy;
            default: class_d = cls_alert;
        endcase
    end

    always_comb begin
        if (speed_set < speed_now) begin
            relation_d = rel_below;
        end else if (speed_set == speed_now) begin
            relation_d = rel_equal;
        end else begin
            relation_d = rel_above;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dec.alert_class <= cls_alert;
            dec.relation    <= rel_equal;
            dec.speed_set   <= '0;
            dec.speed_now   <= '0;
        end else begin
            dec.alert_class <= class_d;
            dec.relation    <= relation_d;
            dec.speed_set   <= speed_set;
            dec.speed_now   <= speed_now;
        end
    end

endmodule

/* rtl/level_fsm.sv */
`timescale 1ns/100ps
`include "speed_ctrl_cfg.svh"

module level_fsm (
    input  logic                        clock,
    input  logic                        rst_n,
    decision_if.sink                    dec,
    output speed_ctrl_pkg::level_t      level,
    output speed_ctrl_pkg::cmd_kind_t   cmd_kind,
    output speed_ctrl_pkg::level_t      offset_index
);
    import speed_ctrl_pkg::*;

    typedef enum level_t {
        lvl_0, lvl_1, lvl_2, lvl_3,
        lvl_4, lvl_5, lvl_6, lvl_7
    } level_state_t;

    localparam level_t LEVEL_TOP = level_t'(`LEVEL_COUNT - 1);
    localparam level_t LEVEL_MID = level_t'(`LEVEL_NEUTRAL);

    level_state_t state;
    level_state_t state_next;
    level_t       level_up;
    level_t       level_down;

    // Neighbours of the present level, clamped at the ends
    assign level_up   = (state == LEVEL_TOP) ? LEVEL_TOP : level_t'(state + 1'b1);
    assign level_down = (state == lvl_0) ? lvl_0 : level_t'(state - 1'b1);

    always_comb begin
        state_next   = state;
        offset_index = state;
        case (dec.alert_class)
            cls_stop, cls_slow: state_next = lvl_0;
            cls_drowsy: begin
                if (state == lvl_7 && dec.relation == rel_above) begin
                    state_next = lvl_6;
                end
            end
            default: begin
                case (dec.relation)
                    rel_below: begin
                        state_next   = level_state_t'(level_up);
                        offset_index = level_up;
                    end
                    rel_above: begin
                        state_next   = level_state_t'(level_down);
                        offset_index = level_down;
                    end
                    default: state_next = level_state_t'(LEVEL_MID);
                endcase
            end
        endcase
    end

    // Neutral index means no offset, hold only when set is above current
    always_comb begin
        if (dec.alert_class == cls_stop) begin
            cmd_kind = cmd_brake;
        end else if (dec.alert_class == cls_slow) begin
            cmd_kind = cmd_slow;
        end else if (dec.alert_class == cls_alert && dec.relation == rel_equal) begin
            cmd_kind = cmd_set;
        end else if (offset_index == LEVEL_MID) begin
            cmd_kind = (dec.relation == rel_above) ? cmd_hold : cmd_set;
        end else begin
            cmd_kind = cmd_offset;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= level_state_t'(LEVEL_MID);
        end else begin
            state <= state_next;
        end
    end

    assign level = state;

endmodule

/* rtl/speed_command.sv */
`timescale 1ns/100ps
`include "speed_ctrl_cfg.svh"

module speed_command (
    input  logic                        clock,
    input  logic                        rst_n,
    decision_if.sink                    dec,
    input  speed_ctrl_pkg::cmd_kind_t   cmd_kind,
    input  speed_ctrl_pkg::level_t      offset_index,
    output logic                        brake,
    output speed_ctrl_pkg::speed_t      speed_cmd
);
    import speed_ctrl_pkg::*;

    localparam int SPEED_MAX = (1 << `SPEED_WIDTH) - 1;

    // Signed speed offset per level, entry 4 is the neutral level
    localparam int OFFSET_TABLE [`LEVEL_COUNT] = '{
        -`STEP_SLOW,
        -`STEP_LARGE,
        -`STEP_MID,
        -`STEP_SMALL,
        0,
        `STEP_SMALL,
        `STEP_MID,
        `STEP_LARGE
    };

    logic   brake_next;
    speed_t speed_next;

    // Add a signed step and clamp to the speed range
    function automatic speed_t sat_add(input speed_t base, input int delta);
        int sum;
        sum = int'(base) + delta;
        if (sum < 0) begin
            return '0;
        end else if (sum > SPEED_MAX) begin
            return '1;
        end
        return speed_t'(sum);
    endfunction

    always_comb begin
        brake_next = 1'b0;
        speed_next = dec.speed_now;
        case (cmd_kind)
            cmd_brake: begin
                brake_next = 1'b1;
                speed_next = '0;
            end
            cmd_slow:   speed_next = sat_add(dec.speed_now, -`STEP_SLOW);
            cmd_offset: speed_next = sat_add(dec.speed_now, OFFSET_TABLE[offset_index]);
            cmd_set:    speed_next = dec.speed_set;
            default:    speed_next = dec.speed_now;
        endcase
    end

    ////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            brake     <= 1'b0;
            speed_cmd <= '0;
        end else begin
            brake     <= brake_next;
            speed_cmd <= speed_next;
        end
    end

endmodule

/* rtl/speed_ctrl_pkg.sv */
`include "speed_ctrl_cfg.svh"

package speed_ctrl_pkg;

    // Plain vectors
    typedef logic [`SPEED_WIDTH-1:0]          speed_t;
    typedef logic [$clog2(`LEVEL_COUNT)-1:0]  level_t;
    typedef logic [`ALERT_WIDTH-1:0]          alert_code_t;

    // Driver alertness classes
    typedef enum logic [1:0] {
        cls_stop,
        cls_slow,
        cls_drowsy,
        cls_alert
    } alert_class_t;

    // Set speed relative to current speed
    typedef enum logic [1:0] {
        rel_below,
        rel_equal,
        rel_above
    } relation_t;

    typedef enum logic [2:0] {
        cmd_brake,
        cmd_slow,
        cmd_offset,
        cmd_set,
        cmd_hold
    } cmd_kind_t;

endpackage

/* rtl/speed_ctrl_top.sv */
`timescale 1ns/100ps

module speed_ctrl_top (
    input  logic                         clock,
    input  logic                         rst_n,
    input  speed_ctrl_pkg::speed_t       speed_set,
    input  speed_ctrl_pkg::speed_t       speed_now,
    input  speed_ctrl_pkg::alert_code_t  alertness,
    output logic                         brake,
    output speed_ctrl_pkg::speed_t       speed_cmd,
    output speed_ctrl_pkg::level_t       level
);
    import speed_ctrl_pkg::*;

    cmd_kind_t cmd_kind;
    level_t    offset_index;

    decision_if dec0 ();

    // Stage 1 registers the samples
    input_classifier classifier0 (
        .clock      (clock),
        .rst_n      (rst_n),
        .speed_set  (speed_set),
        .speed_now  (speed_now),
        .alertness  (alertness),
        .dec        (dec0.source)
    );

    // Stage 2 updates level and outputs together
    level_fsm fsm0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .dec          (dec0.sink),
        .level        (level),
        .cmd_kind     (cmd_kind),
        .offset_index (offset_index)
    );

    speed_command command0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .dec          (dec0.sink),
        .cmd_kind     (cmd_kind),
        .offset_index (offset_index),
        .brake        (brake),
        .speed_cmd    (speed_cmd)
    );

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Release just after an edge so no sample sees it change
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 rst_n = 1'b1;
    end

endmodule

/* verification/speed_ctrl_properties.sv */
`timescale 1ns/100ps
`include "speed_ctrl_cfg.svh"

module speed_ctrl_properties (
    input logic                    clock,
    input logic                    rst_n,
    input logic                    brake,
    input speed_ctrl_pkg::speed_t  speed_cmd,
    input speed_ctrl_pkg::level_t  level
);

    int unsigned failures = 0;

    brake_clears_speed: assert property (
        @(posedge clock) disable iff (!rst_n)
        brake |-> (speed_cmd == '0)
    ) else begin
        failures++;
        $error("brake is set while speed_cmd is not zero");
    end

    // Jumps are only allowed to zero or to neutral
    level_moves_one_step: assert property (
        @(posedge clock) disable iff (!rst_n)
        (level != $past(level)) |->
            (level == 0 || level == `LEVEL_NEUTRAL ||
             level == $past(level) + 1 || level == $past(level) - 1)
    ) else begin
        failures++;
        $error("level moved by more than one step");
    end

    outputs_reset: assert property (
        @(posedge clock)
        !rst_n |=> (!brake && speed_cmd == '0 && level == `LEVEL_NEUTRAL)
    ) else begin
        failures++;
        $error("outputs left their reset values during reset");
    end

endmodule

bind speed_ctrl_top speed_ctrl_properties props0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .brake     (brake),
    .speed_cmd (speed_cmd),
    .level     (level)
);

/* verification/speed_ctrl_tb.sv */
`timescale 1ns/100ps
`include "speed_ctrl_cfg.svh"

module speed_ctrl_tb;
    import speed_ctrl_pkg::*;

    localparam int CLOCK_PERIOD     = 4;
    localparam int DRIVE_DELAY      = 1;
    localparam int DIRECTED_SAMPLES = 40;
    localparam int RANDOM_SAMPLES   = 500;
    localparam int TIMEOUT_CYCLES   = DIRECTED_SAMPLES + RANDOM_SAMPLES + 10;
    localparam int SPEED_MAX        = (1 << `SPEED_WIDTH) - 1;

    typedef struct packed {
        logic   brake;
        speed_t speed;
        level_t level;
    } expect_t;

    logic        clock;
    logic        rst_n;
    speed_t      speed_set;
    speed_t      speed_now;
    alert_code_t alertness;
    logic        brake;
    speed_t      speed_cmd;
    level_t      level;

    expect_t     pending [$];
    level_t      model_level;
    logic [31:0] lcg_state = 32'h073b_902f;
    int          checks_done = 0;

    clock_gen #(.HALF_PERIOD(CLOCK_PERIOD / 2), .RESET_CYCLES(3)) clock0 (
        .clock (clock),
        .rst_n (rst_n)
    );

    speed_ctrl_top dut0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .speed_set (speed_set),
        .speed_now (speed_now),
        .alertness (alertness),
        .brake     (brake),
        .speed_cmd (speed_cmd),
        .level     (level)
    );

    ////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic speed_t clamp_speed(input int value);
        if (value < 0) begin
            return '0;
        end
        if (value > SPEED_MAX) begin
            return speed_t'(SPEED_MAX);
        end
        return speed_t'(value);
    endfunction

    function automatic int step_for(input level_t index);
        case (index)
            3'd0:    return -`STEP_SLOW;
            3'd1:    return -`STEP_LARGE;
            3'd2:    return -`STEP_MID;
            3'd3:    return -`STEP_SMALL;
            3'd5:    return `STEP_SMALL;
            3'd6:    return `STEP_MID;
            3'd7:    return `STEP_LARGE;
            default: return 0;
        endcase
    endfunction

    // Result two cycles after the sample, and the level it leaves behind
    function automatic expect_t reference_result(input speed_t set_speed,
                                                 input speed_t cur_speed,
                                                 input alert_code_t code,
                                                 input level_t present);
        expect_t result;
        level_t  index;
        logic    above;
        logic    below;
        above = set_speed > cur_speed;
        below = set_speed < cur_speed;
        result.brake = 1'b0;
        result.speed = cur_speed;
        result.level = present;
        if (code == 3'b000) begin
            result.brake = 1'b1;
            result.speed = '0;
            result.level = '0;
            return result;
        end
        if (code == 3'b001) begin
            result.speed = clamp_speed(int'(cur_speed) - `STEP_SLOW);
            result.level = '0;
            return result;
        end
        if (code[2] && !above && !below) begin
            result.speed = set_speed;
            result.level = level_t'(`LEVEL_NEUTRAL);
            return result;
        end
        if (!code[2]) begin
            index = present;
            if (present == 3'd7 && above) begin
                result.level = 3'd6;
            end
        end else if (below) begin
            index = (present == 3'd7) ? 3'd7 : present + 3'd1;
            result.level = index;
        end else begin
            index = (present == 3'd0) ? 3'd0 : present - 3'd1;
            result.level = index;
        end
        if (index == `LEVEL_NEUTRAL) begin
            result.speed = above ? cur_speed : set_speed;
        end else begin
            result.speed = clamp_speed(int'(cur_speed) + step_for(index));
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////

    task automatic report_mismatch(input string what);
        $display("** Error at %0t: %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_speed(input speed_t got, input speed_t expected);
        if (got !== expected) begin
            report_mismatch($sformatf("speed_cmd is %0d, expected %0d", got, expected));
        end
    endtask

    task automatic check_level(input level_t got, input level_t expected);
        if (got !== expected) begin
            report_mismatch($sformatf("level is %0d, expected %0d", got, expected));
        end
    endtask

    task automatic check_brake(input logic got, input logic expected);
        if (got !== expected) begin
            report_mismatch($sformatf("brake is %b, expected %b", got, expected));
        end
    endtask

    task automatic drive_repeat(input speed_t set_value, input speed_t now_value,
                                input alert_code_t code, input int count);
        repeat (count) begin
            @(posedge clock);
            #DRIVE_DELAY;
            speed_set = set_value;
            speed_now = now_value;
            alertness = code;
        end
    endtask

    // Outputs right after reset come from the classifier's reset contents
    initial begin : compare
        expect_t expected;
        model_level = level_t'(`LEVEL_NEUTRAL);
        pending.push_back('{brake: 1'b0, speed: '0, level: level_t'(`LEVEL_NEUTRAL)});
        forever begin
            @(posedge clock);
            if (rst_n) begin
                expected = reference_result(speed_set, speed_now, alertness, model_level);
                model_level = expected.level;
                pending.push_back(expected);
                @(negedge clock);
                expected = pending.pop_front();
                check_brake(brake, expected.brake);
                check_speed(speed_cmd, expected.speed);
                check_level(level, expected.level);
                checks_done++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Run timed out after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] r;
        speed_t      set_value;
        speed_set = '0;
        speed_now = '0;
        alertness = 3'b100;
        wait (rst_n);

        drive_repeat(8'd0, 8'd0, 3'b100, 4);
        // Stop, then slow with and without saturation
        drive_repeat(8'd100, 8'd80, 3'b000, 2);
        drive_repeat(8'd50, 8'd100, 3'b001, 1);
        drive_repeat(8'd50, 8'd12, 3'b001, 1);
        // Neutral, walk up to 7 and stay
        drive_repeat(8'd90, 8'd90, 3'b110, 1);
        drive_repeat(8'd60, 8'd120, 3'b101, 5);
        // Walk down to 0, hold at index 4
        drive_repeat(8'd200, 8'd100, 3'b111, 9);
        drive_repeat(8'd40, 8'd70, 3'b100, 5);
        // Drowsy near the top of the range
        drive_repeat(8'd0, 8'd252, 3'b010, 2);
        drive_repeat(8'd30, 8'd60, 3'b100, 2);
        drive_repeat(8'd50, 8'd100, 3'b011, 1);
        drive_repeat(8'd250, 8'd245, 3'b010, 1);
        drive_repeat(8'd10, 8'd100, 3'b011, 1);
        // Drowsy near zero
        drive_repeat(8'd0, 8'd0, 3'b000, 1);
        drive_repeat(8'd0, 8'd7, 3'b010, 2);
        drive_repeat(8'd90, 8'd90, 3'b111, 2);

        // Some equal speeds so alert-equal shows up
        for (int i = 0; i < RANDOM_SAMPLES; i++) begin
            r = next_random();
            set_value = r[31:24];
            if (r[13:12] == 2'b00) begin
                set_value = r[23:16];
            end
            drive_repeat(set_value, r[23:16], r[10:8], 1);
        end

        repeat (3) @(posedge clock);
        if (checks_done > 0 && dut0.props0.failures == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            if (checks_done == 0) begin
                $display("No output was ever compared");
            end
            if (dut0.props0.failures != 0) begin
                $display("%0d property assertions failed", dut0.props0.failures);
            end
            $display("Testbench failed");
            $fatal(1, "Run ended with failures");
        end
    end

endmodule
